// File: rtl/tpu_pkg.sv
package tpu_pkg;

    localparam int LANES = 4;   // Array rows and columns, also elements per operand word

    typedef logic [7:0]  elem_t;
    typedef logic [7:0]  dim_t;
    typedef logic [15:0] index_t;
    typedef logic [31:0] acc_t;

    // Lane 0 sits in the top byte
    typedef logic [LANES*$bits(elem_t)-1:0] operand_word_t;

    // Column 0 sits in the top word
    typedef logic [LANES*$bits(acc_t)-1:0] result_word_t;

    typedef logic [$clog2(LANES)-1:0] lane_sel_t;

    // Steps to drain the skewed wavefront after the last operand
    localparam index_t CALC_TAIL = 16'd6;

    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_CALC = 2'd1,
        SEQ_DONE = 2'd2
    } seq_state_t;

endpackage

// File: rtl/array_ctrl_if.sv
`timescale 1ns/1ps

interface array_ctrl_if;

    logic               clear;       // New job
    logic               step;        // Advance the wavefront one cycle
    logic               flush;       // Last store of a tile done
    logic               a_pad;
    logic               b_pad;
    tpu_pkg::lane_sel_t store_row;

    modport seq   (output clear, output step, output flush,
                   output a_pad, output b_pad, output store_row);

    modport skew  (input clear, input step, input a_pad, input b_pad);

    modport array (input clear, input step, input flush, input store_row);

endinterface

// File: rtl/tpu_config.sv
`timescale 1ns/1ps

module tpu_config (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  tpu_pkg::dim_t   k,
    input  tpu_pkg::dim_t   m,
    input  tpu_pkg::dim_t   n,
    output tpu_pkg::index_t size_k,
    output tpu_pkg::index_t size_m,
    output tpu_pkg::index_t a_words,
    output tpu_pkg::index_t b_words,
    output tpu_pkg::index_t c_words
);

    localparam int LANE_SHIFT = $clog2(tpu_pkg::LANES);

    // Number of operand words needed to cover len lanes
    function automatic tpu_pkg::index_t blocks_of(tpu_pkg::dim_t len);
        return (tpu_pkg::index_t'(len) + tpu_pkg::index_t'(tpu_pkg::LANES - 1)) >> LANE_SHIFT;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            size_k  <= '0;
            size_m  <= '0;
            a_words <= '0;
            b_words <= '0;
            c_words <= '0;
        end else if (in_valid) begin
            size_k  <= tpu_pkg::index_t'(k);
            size_m  <= tpu_pkg::index_t'(m);
            a_words <= tpu_pkg::index_t'(k) * blocks_of(m);   // K words per row block
            b_words <= tpu_pkg::index_t'(k) * blocks_of(n);
            c_words <= tpu_pkg::index_t'(m) * blocks_of(n);   // M rows per column block
        end
    end

endmodule

// File: rtl/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  tpu_pkg::index_t size_k,
    input  tpu_pkg::index_t size_m,
    input  tpu_pkg::index_t a_words,
    input  tpu_pkg::index_t b_words,
    input  tpu_pkg::index_t c_words,
    output logic            busy,
    output tpu_pkg::index_t a_index,
    output tpu_pkg::index_t b_index,
    output tpu_pkg::index_t c_index,
    output logic            c_wr_en,
    array_ctrl_if.seq       ctrl
);

    tpu_pkg::seq_state_t state;
    tpu_pkg::seq_state_t state_next;

    tpu_pkg::index_t a_cnt;
    tpu_pkg::index_t b_cnt;
    tpu_pkg::index_t c_cnt;
    tpu_pkg::index_t row_blk;    // Counts from 1 so the tile ends at row_blk*K
    tpu_pkg::index_t col_blk;
    tpu_pkg::index_t load_cnt;
    tpu_pkg::index_t calc_cnt;
    logic [$clog2(tpu_pkg::LANES):0] store_cnt;

    tpu_pkg::index_t a_end;
    tpu_pkg::index_t b_end;
    tpu_pkg::index_t c_end;

    logic start;
    logic in_calc;
    logic load_done;
    logic calc_done;
    logic tile_done;
    logic col_done;
    logic store_done;
    logic job_done;
    logic flush;
    logic rearm;

    assign start   = in_valid && (state == tpu_pkg::SEQ_IDLE);
    assign in_calc = (state == tpu_pkg::SEQ_CALC);

    assign a_end = row_blk * size_k;
    assign b_end = col_blk * size_k;
    assign c_end = col_blk * size_m;   // Last C word of this column block

    assign load_done  = (load_cnt >= size_k);
    assign calc_done  = (calc_cnt >= size_k + tpu_pkg::CALC_TAIL);
    assign tile_done  = calc_done && (a_cnt >= a_end) && (b_cnt >= b_end);
    assign col_done   = tile_done && (a_cnt >= a_words);
    assign store_done = (store_cnt >= tpu_pkg::LANES) || (c_cnt >= c_end);
    assign job_done   = (a_cnt >= a_words) && (b_cnt >= b_words) && (c_cnt >= c_words);
    assign flush      = in_calc && tile_done && store_done;
    assign rearm      = calc_done && !tile_done;    // Gap cycle before the next tile

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Job state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tpu_pkg::SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            tpu_pkg::SEQ_IDLE: state_next = start ? tpu_pkg::SEQ_CALC : tpu_pkg::SEQ_IDLE;
            tpu_pkg::SEQ_CALC: state_next = job_done ? tpu_pkg::SEQ_DONE : tpu_pkg::SEQ_CALC;
            default:           state_next = tpu_pkg::SEQ_IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand addresses and tile position
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_cnt <= '0;
            b_cnt <= '0;
        end else if (start) begin
            a_cnt <= '0;
            b_cnt <= '0;
        end else if (flush) begin
            if (col_done) begin
                a_cnt <= '0;                 // B already points at the next column
            end else begin
                b_cnt <= b_end - size_k;     // Same column, next row block
            end
        end else if (in_calc && !load_done) begin
            if (a_cnt < a_words) begin
                a_cnt <= a_cnt + 16'd1;
            end
            if (b_cnt < b_words) begin
                b_cnt <= b_cnt + 16'd1;
            end
        end
    end

    // Row blocks inner, column blocks outer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_blk <= 16'd1;
            col_blk <= 16'd1;
        end else if (start) begin
            row_blk <= 16'd1;
            col_blk <= 16'd1;
        end else if (flush) begin
            if (col_done) begin
                row_blk <= 16'd1;
                col_blk <= col_blk + 16'd1;
            end else begin
                row_blk <= row_blk + 16'd1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load, compute and store phases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt <= '0;
            calc_cnt <= '0;
        end else if (start || rearm) begin
            load_cnt <= '0;
            calc_cnt <= '0;
        end else if (in_calc) begin
            if (!load_done) begin
                load_cnt <= load_cnt + 16'd1;
            end
            // Starts one cycle behind the first load
            if (!calc_done && (load_cnt != '0 || load_done)) begin
                calc_cnt <= calc_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_cnt     <= '0;
            store_cnt <= '0;
        end else if (start) begin
            c_cnt     <= '0;
            store_cnt <= '0;
        end else if (flush) begin
            store_cnt <= '0;
        end else if (c_wr_en) begin
            c_cnt     <= c_cnt + 16'd1;
            store_cnt <= store_cnt + 1'b1;
        end
    end

    assign c_wr_en = in_calc && tile_done && !store_done;
    assign busy    = in_calc;
    assign a_index = a_cnt;
    assign b_index = b_cnt;
    assign c_index = c_cnt;

    assign ctrl.clear     = start;
    assign ctrl.step      = in_calc && !calc_done;
    assign ctrl.flush     = flush;
    assign ctrl.a_pad     = (a_cnt >= a_end);   // Past this tile's K words
    assign ctrl.b_pad     = (b_cnt >= b_end);
    assign ctrl.store_row = tpu_pkg::lane_sel_t'(store_cnt);

endmodule

// File: rtl/operand_skew.sv
`timescale 1ns/1ps

module operand_skew (
    input  logic                                clk,
    input  logic                                rst_n,
    input  tpu_pkg::operand_word_t              a_data,
    input  tpu_pkg::operand_word_t              b_data,
    array_ctrl_if.skew                          ctrl,
    output tpu_pkg::elem_t [tpu_pkg::LANES-1:0] a_lanes,
    output tpu_pkg::elem_t [tpu_pkg::LANES-1:0] b_lanes
);

    localparam int LANES = tpu_pkg::LANES;
    localparam int EW    = $bits(tpu_pkg::elem_t);

    // Index 0 is A, index 1 is B
    tpu_pkg::operand_word_t word [2];

    // Lane r uses stages r down to 0, stage 0 feeds the array
    tpu_pkg::elem_t stage [2][LANES][LANES];

    assign word[0] = ctrl.a_pad ? '0 : a_data;
    assign word[1] = ctrl.b_pad ? '0 : b_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage <= '{default: '0};
        end else if (ctrl.clear) begin
            stage <= '{default: '0};
        end else if (ctrl.step) begin
            for (int op = 0; op < 2; op++) begin
                for (int r = 0; r < LANES; r++) begin
                    for (int s = 0; s < r; s++) begin
                        stage[op][r][s] <= stage[op][r][s+1];
                    end
                    stage[op][r][r] <= word[op][EW*(LANES-1-r) +: EW];   // Top byte is lane 0
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < LANES; r++) begin
            a_lanes[r] = stage[0][r][0];
            b_lanes[r] = stage[1][r][0];
        end
    end

endmodule

// File: rtl/mac_cell.sv
`timescale 1ns/1ps

module mac_cell (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clear,
    input  logic           step,
    input  logic           flush,
    input  tpu_pkg::elem_t a_in,
    input  tpu_pkg::elem_t b_in,
    output tpu_pkg::elem_t a_out,
    output tpu_pkg::elem_t b_out,
    output tpu_pkg::acc_t  acc
);

    tpu_pkg::acc_t product;

    assign product = a_in * b_in;   // Unsigned, widened to the accumulator

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (clear || flush) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (step) begin
            a_out <= a_in;   // A moves right
            b_out <= b_in;   // B moves down
            acc   <= acc + product;
        end
    end

endmodule

// File: rtl/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
    input  logic                                clk,
    input  logic                                rst_n,
    input  tpu_pkg::elem_t [tpu_pkg::LANES-1:0] a_lanes,
    input  tpu_pkg::elem_t [tpu_pkg::LANES-1:0] b_lanes,
    array_ctrl_if.array                         ctrl,
    output tpu_pkg::result_word_t               row_data
);

    localparam int LANES = tpu_pkg::LANES;
    localparam int ACC_W = $bits(tpu_pkg::acc_t);

    tpu_pkg::elem_t a_link [LANES][LANES+1];   // Column index along the row
    tpu_pkg::elem_t b_link [LANES+1][LANES];   // Row index down the column
    tpu_pkg::acc_t  acc    [LANES][LANES];

    for (genvar r = 0; r < LANES; r++) begin : g_edge
        assign a_link[r][0] = a_lanes[r];
        assign b_link[0][r] = b_lanes[r];
    end

    for (genvar row = 0; row < LANES; row++) begin : g_row
        for (genvar col = 0; col < LANES; col++) begin : g_col
            mac_cell u_cell (
                .clk   (clk),
                .rst_n (rst_n),
                .clear (ctrl.clear),
                .step  (ctrl.step),
                .flush (ctrl.flush),
                .a_in  (a_link[row][col]),
                .b_in  (b_link[row][col]),
                .a_out (a_link[row][col+1]),
                .b_out (b_link[row+1][col]),
                .acc   (acc[row][col])
            );
        end
    end

    // Result row for write-back, column 0 in the top word
    always_comb begin
        for (int col = 0; col < LANES; col++) begin
            row_data[ACC_W*(LANES-1-col) +: ACC_W] = acc[ctrl.store_row][col];
        end
    end

endmodule

// File: rtl/tpu_top.sv
`timescale 1ns/1ps

module tpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  tpu_pkg::dim_t          k,
    input  tpu_pkg::dim_t          m,
    input  tpu_pkg::dim_t          n,
    output logic                   busy,
    output tpu_pkg::index_t        a_index,
    input  tpu_pkg::operand_word_t a_data,
    output tpu_pkg::index_t        b_index,
    input  tpu_pkg::operand_word_t b_data,
    output logic                   c_wr_en,
    output tpu_pkg::index_t        c_index,
    output tpu_pkg::result_word_t  c_data
);

    tpu_pkg::index_t size_k;
    tpu_pkg::index_t size_m;
    tpu_pkg::index_t a_words;
    tpu_pkg::index_t b_words;
    tpu_pkg::index_t c_words;

    tpu_pkg::elem_t [tpu_pkg::LANES-1:0] a_lanes;
    tpu_pkg::elem_t [tpu_pkg::LANES-1:0] b_lanes;

    array_ctrl_if ctrl_bus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    tpu_config u_config (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .k        (k),
        .m        (m),
        .n        (n),
        .size_k   (size_k),
        .size_m   (size_m),
        .a_words  (a_words),
        .b_words  (b_words),
        .c_words  (c_words)
    );

    tile_sequencer u_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .size_k   (size_k),
        .size_m   (size_m),
        .a_words  (a_words),
        .b_words  (b_words),
        .c_words  (c_words),
        .busy     (busy),
        .a_index  (a_index),
        .b_index  (b_index),
        .c_index  (c_index),
        .c_wr_en  (c_wr_en),
        .ctrl     (ctrl_bus)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    operand_skew u_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_data  (a_data),
        .b_data  (b_data),
        .ctrl    (ctrl_bus),
        .a_lanes (a_lanes),
        .b_lanes (b_lanes)
    );

    systolic_array u_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_lanes  (a_lanes),
        .b_lanes  (b_lanes),
        .ctrl     (ctrl_bus),
        .row_data (c_data)   // Row picked by the store counter
    );

endmodule

// File: bench/tpu_properties.sv
`timescale 1ns/1ps

module tpu_properties (
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input tpu_pkg::dim_t   m,
    input tpu_pkg::dim_t   n,
    input logic            busy,
    input logic            c_wr_en,
    input tpu_pkg::index_t c_index
);

    tpu_pkg::index_t c_limit;   // M rows per column block
    int failures = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_limit <= '0;
        end else if (in_valid && !busy) begin
            c_limit <= tpu_pkg::index_t'(m) * ((tpu_pkg::index_t'(n) + 16'd3) >> 2);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    write_inside_job: assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> busy)
        else begin
            failures++;
            $error("c_wr_en is high while busy is low");
        end

    write_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> (c_index < c_limit))
        else begin
            failures++;
            $error("c_index %0d is outside the C range of %0d words", c_index, c_limit);
        end

    start_raises_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !busy) |=> busy)
        else begin
            failures++;
            $error("busy did not rise the cycle after an accepted in_valid");
        end

    quiet_in_reset: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (!busy && !c_wr_en))
        else begin
            failures++;
            $error("busy or c_wr_en is high during or right after reset");
        end

endmodule

bind tpu_top tpu_properties u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .m        (m),
    .n        (n),
    .busy     (busy),
    .c_wr_en  (c_wr_en),
    .c_index  (c_index)
);

// File: bench/tb_tpu.sv
`timescale 1ns/1ps

module tb_tpu;

    localparam int MEM_DEPTH   = 256;
    localparam int MAX_DIM     = 64;
    localparam int RISE_LIMIT  = 10;
    localparam int FALL_LIMIT  = 20000;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   in_valid;
    tpu_pkg::dim_t          k;
    tpu_pkg::dim_t          m;
    tpu_pkg::dim_t          n;
    logic                   busy;
    tpu_pkg::index_t        a_index;
    tpu_pkg::index_t        b_index;
    tpu_pkg::index_t        c_index;
    tpu_pkg::operand_word_t a_data;
    tpu_pkg::operand_word_t b_data;
    logic                   c_wr_en;
    tpu_pkg::result_word_t  c_data;

    tpu_pkg::operand_word_t a_mem [MEM_DEPTH];
    tpu_pkg::operand_word_t b_mem [MEM_DEPTH];
    tpu_pkg::result_word_t  c_mem [MEM_DEPTH];
    int                     write_cnt [MEM_DEPTH];
    int                     stray_writes;
    int                     c_range;

    tpu_pkg::elem_t mat_a [MAX_DIM][MAX_DIM];   // [row][k]
    tpu_pkg::elem_t mat_b [MAX_DIM][MAX_DIM];   // [k][col]

    logic [15:0] lfsr;
    int          errors = 0;
    int          timeouts = 0;

    always #5 clk = ~clk;

    tpu_top u_dut (.*);

    // Both operand memories read in the same cycle
    assign a_data = a_mem[a_index];
    assign b_data = b_mem[b_index];

    always @(posedge clk) begin
        if (c_wr_en) begin
            if (c_index < c_range) begin
                c_mem[c_index]     <= c_data;
                write_cnt[c_index] <= write_cnt[c_index] + 1;
            end else begin
                stray_writes++;
            end
        end
    end

    // Galois LFSR stepped once per bit
    function automatic int unsigned draw_bits(int width);
        int unsigned val;
        logic        lsb;
        val = 0;
        for (int i = 0; i < width; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 16'hB400;
            end
            val = (val << 1) | lsb;
        end
        return val;
    endfunction

    task automatic finish_run();
        $display("Summary: %0d check errors, %0d timeouts, %0d property failures",
                 errors, timeouts, u_dut.u_props.failures);
        if (errors == 0 && timeouts == 0 && u_dut.u_props.failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Compare every C word of the finished job against A times B
    task automatic check_results(input string name, input int kk, input int mm,
                                 input int nn);
        int                    idx;
        tpu_pkg::result_word_t exp_word;
        tpu_pkg::acc_t         sum;
        for (int blk = 0; blk < (nn + 3) / 4; blk++) begin
            for (int row = 0; row < mm; row++) begin
                idx      = blk * mm + row;
                exp_word = '0;
                for (int c = 0; c < 4; c++) begin
                    sum = '0;
                    if (4 * blk + c < nn) begin
                        for (int j = 0; j < kk; j++) begin
                            sum += tpu_pkg::acc_t'(mat_a[row][j]) *
                                   tpu_pkg::acc_t'(mat_b[j][4*blk+c]);
                        end
                    end
                    exp_word[32*(3-c) +: 32] = sum;
                end
                assert (c_mem[idx] === exp_word) else begin
                    $display("ERROR %s: C word %0d expected %h actual %h",
                             name, idx, exp_word, c_mem[idx]);
                    errors++;
                end
                assert (write_cnt[idx] == 1) else begin
                    $display("ERROR %s: C word %0d write count expected 1 actual %0d",
                             name, idx, write_cnt[idx]);
                    errors++;
                end
            end
        end
        assert (stray_writes == 0) else begin
            $display("In %s, %0d writes landed outside the C range", name, stray_writes);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load memories, run one job and compare C
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_job(input string name, input int kk, input int mm, input int nn);
        int                     cycles;
        tpu_pkg::operand_word_t word;
        for (int r = 0; r < mm; r++) begin
            for (int j = 0; j < kk; j++) begin
                mat_a[r][j] = tpu_pkg::elem_t'(draw_bits(8));
            end
        end
        for (int j = 0; j < kk; j++) begin
            for (int c = 0; c < nn; c++) begin
                mat_b[j][c] = tpu_pkg::elem_t'(draw_bits(8));
            end
        end
        // Lanes past M or N stay zero
        for (int blk = 0; blk < (mm + 3) / 4; blk++) begin
            for (int j = 0; j < kk; j++) begin
                word = '0;
                for (int r = 0; r < 4; r++) begin
                    if (4 * blk + r < mm) word[8*(3-r) +: 8] = mat_a[4*blk+r][j];
                end
                a_mem[blk*kk+j] = word;
            end
        end
        for (int blk = 0; blk < (nn + 3) / 4; blk++) begin
            for (int j = 0; j < kk; j++) begin
                word = '0;
                for (int c = 0; c < 4; c++) begin
                    if (4 * blk + c < nn) word[8*(3-c) +: 8] = mat_b[j][4*blk+c];
                end
                b_mem[blk*kk+j] = word;
            end
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            c_mem[i]     = '0;
            write_cnt[i] = 0;
        end
        stray_writes = 0;
        c_range      = mm * ((nn + 3) / 4);

        @(posedge clk);
        in_valid <= 1'b1;
        k        <= tpu_pkg::dim_t'(kk);
        m        <= tpu_pkg::dim_t'(mm);
        n        <= tpu_pkg::dim_t'(nn);
        @(posedge clk);
        in_valid <= 1'b0;

        cycles = 0;
        @(negedge clk);
        while (!busy && cycles < RISE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!busy) begin
            $display("Timeout in %s: busy never rose after the start strobe", name);
            timeouts++;
        end else begin
            cycles = 0;
            while (busy && cycles < FALL_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (busy) begin
                $display("Timeout in %s: busy stayed high, the job never ended", name);
                timeouts++;
            end else begin
                check_results(name, kk, mm, nn);
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        k        = '0;
        m        = '0;
        n        = '0;
        lfsr     = 16'd41398;
        c_range  = 0;
        stray_writes = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            a_mem[i] = '0;
            b_mem[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        run_job("single_tile", 3, 4, 4);
        if (timeouts == 0) begin
            run_job("partial_lanes", 1 + int'(draw_bits(4)), 5, 6);
        end
        if (timeouts == 0) begin
            run_job("large_k", 40, 8, 4);
        end
        // Each start follows the previous fall of busy
        for (int j = 0; j < 3 && timeouts == 0; j++) begin
            run_job($sformatf("back_to_back_%0d", j), 1 + int'(draw_bits(3)),
                    1 + int'(draw_bits(3)), 1 + int'(draw_bits(3)));
        end
        finish_run();
    end

endmodule

// File: files.f
rtl/tpu_pkg.sv
rtl/array_ctrl_if.sv
rtl/tpu_config.sv
rtl/tile_sequencer.sv
rtl/operand_skew.sv
rtl/mac_cell.sv
rtl/systolic_array.sv
rtl/tpu_top.sv
bench/tpu_properties.sv
bench/tb_tpu.sv
